// File: src/tcp_ctrl_consts.svh
`ifndef TCP_CTRL_CONSTS_SVH
`define TCP_CTRL_CONSTS_SVH

// Number of transmit buffers behind the arbiter
`define TCP_BUF_NUM 8

// Initial send sequence number
`define TCP_ISS 32'd0

// Data segments allowed before the peer acknowledges
`define TCP_MAX_INFLIGHT 16

// Usable window in bytes needed to start a data segment
`define TCP_MIN_WINDOW 25000

// Local port, known to the segment encoder
`define TCP_LOCAL_PORT 16'd63256

`endif

// File: src/tcp_ctrl_pkg.sv
`default_nettype none

`include "tcp_ctrl_consts.svh"

package tcp_ctrl_pkg;

	typedef logic [31:0] seq_t;

	typedef logic [$clog2(`TCP_BUF_NUM)-1:0] buf_idx_t;

	// Bit order as on the wire, urg is bit 5
	typedef struct packed {
		logic urg;
		logic ack;
		logic psh;
		logic rst;
		logic syn;
		logic fin;
	} tcp_flags_t;

	typedef struct packed {
		logic [15:0] src_port;
		logic [15:0] dst_port;
		tcp_flags_t  flags;
		seq_t        seq;
		seq_t        ack;
		logic [15:0] len;
		logic [15:0] window;
	} rx_seg_t;

	typedef struct packed {
		logic [15:0] dst_port;
		tcp_flags_t  flags;
		seq_t        seq;
		seq_t        ack;
		logic [15:0] len;
		buf_idx_t    buf_idx;
	} tx_cmd_t;

	typedef enum logic [5:0] {
		ST_LISTEN      = 6'b00_0001,
		ST_SYN_RCVD    = 6'b00_0010,
		ST_ESTABLISHED = 6'b00_0100,
		ST_CLOSE_WAIT  = 6'b00_1000,
		ST_LAST_ACK    = 6'b01_0000,
		ST_CLOSED      = 6'b10_0000
	} conn_state_t;

	typedef enum logic [2:0] {
		EV_NONE,
		EV_SYNACK,
		EV_RSTACK,
		EV_ACK,
		EV_FIN_SEEN,
		EV_FINACK,
		EV_OPEN,
		EV_DATA
	} ev_kind_t;

	typedef struct packed {
		ev_kind_t kind;
		rx_seg_t  seg;
	} ctrl_ev_t;

endpackage

`default_nettype wire

// File: src/seg_slice.sv
`timescale 1ns/1ps
`default_nettype none

module seg_slice #(
	parameter type payload_t = logic [7:0]
) (
	input  wire       clk,
	input  wire       rst_n,

	input  wire       in_valid_i,
	output logic      in_ready_o,
	input  wire       payload_t in_data_i,

	output logic      out_valid_o,
	input  wire       out_ready_i,
	output payload_t  out_data_o
);

	// Two-entry storage
	payload_t mem [2];

	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] count;
	logic       push;
	logic       pop;

	// Ready comes from the count only, so no path from out_ready_i
	assign in_ready_o  = (count != 2'd2);
	assign out_valid_o = (count != 2'd0);
	assign out_data_o  = mem[rd_ptr];

	assign push = in_valid_i & in_ready_o;
	assign pop  = out_valid_o & out_ready_i;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end
		else
		begin
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			count <= count + 2'(push) - 2'(pop);
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in_data_i;
	end

endmodule

`default_nettype wire

// File: src/tcp_conn_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_conn_fsm (
	input  wire                    clk,
	input  wire                    rst_n,

	input  wire                    seg_valid_i,
	output logic                   seg_ready_o,
	input  wire tcp_ctrl_pkg::rx_seg_t seg_i,

	output logic                   ev_valid_o,
	input  wire                    ev_ready_i,
	output tcp_ctrl_pkg::ctrl_ev_t ev_o,
	output logic [15:0]            peer_port_o,

	input  wire                    send_ok_i,
	input  wire                    buf_sel_valid_i,

	output logic                   state_listen_o,
	output logic                   state_estab_o
);

	import tcp_ctrl_pkg::*;

	conn_state_t state_q;
	conn_state_t state_d;
	ev_kind_t    ev_kind;
	logic        seg_fire;
	logic [15:0] peer_port_q;

	// Segments wait in the slice while closing down
	assign seg_ready_o = ev_ready_i & (state_q != ST_CLOSE_WAIT) & (state_q != ST_CLOSED);
	assign seg_fire    = seg_valid_i & seg_ready_o;

	// --------------------
	// Next state and event
	// --------------------
	always_comb
	begin
		state_d    = state_q;
		ev_valid_o = 1'b0;
		ev_kind    = EV_NONE;
		case (state_q)
			ST_LISTEN:
			begin
				if (seg_fire && !seg_i.flags.rst)
				begin
					if (seg_i.flags.ack)
					begin
						ev_valid_o = 1'b1;
						ev_kind    = EV_RSTACK;
					end
					else if (seg_i.flags.syn)
					begin
						ev_valid_o = 1'b1;
						ev_kind    = EV_SYNACK;
						state_d    = ST_SYN_RCVD;
					end
				end
			end
			ST_SYN_RCVD:
			begin
				if (seg_fire)
				begin
					if (seg_i.flags.rst)
						state_d = ST_LISTEN;
					else if (seg_i.flags.syn)
						state_d = ST_CLOSED;
					else if (seg_i.flags.ack)
					begin
						ev_valid_o = 1'b1;
						ev_kind    = EV_OPEN;
						state_d    = ST_ESTABLISHED;
					end
				end
			end
			ST_ESTABLISHED:
			begin
				if (seg_fire)
				begin
					// Every segment here reaches the builder for the window
					ev_valid_o = 1'b1;
					if (seg_i.flags.rst && (seg_i.src_port == peer_port_q))
						state_d = ST_CLOSED;
					else if (seg_i.flags.fin)
					begin
						ev_kind = EV_FIN_SEEN;
						state_d = ST_CLOSE_WAIT;
					end
					else if (seg_i.flags.ack && (seg_i.len != 16'd0))
						ev_kind = EV_ACK;
				end
				else if (!seg_valid_i && send_ok_i && buf_sel_valid_i && ev_ready_i)
				begin
					ev_valid_o = 1'b1;
					ev_kind    = EV_DATA;
				end
			end
			ST_CLOSE_WAIT:
			begin
				if (ev_ready_i)
				begin
					ev_valid_o = 1'b1;
					ev_kind    = EV_FINACK;
					state_d    = ST_LAST_ACK;
				end
			end
			ST_LAST_ACK:
			begin
				if (seg_fire && (seg_i.flags.ack || seg_i.flags.rst))
					state_d = ST_CLOSED;
			end
			default:
				state_d = ST_LISTEN;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q     <= ST_LISTEN;
			peer_port_q <= 16'd0;
		end
		else
		begin
			state_q <= state_d;
			if (ev_valid_o && (ev_kind == EV_SYNACK))
				peer_port_q <= seg_i.src_port;
		end
	end

	assign ev_o.kind      = ev_kind;
	assign ev_o.seg       = seg_i;
	assign peer_port_o    = peer_port_q;
	assign state_listen_o = (state_q == ST_LISTEN);
	assign state_estab_o  = (state_q == ST_ESTABLISHED);

endmodule

`default_nettype wire

// File: src/tcp_seg_builder.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_ctrl_consts.svh"

module tcp_seg_builder (
	input  wire                        clk,
	input  wire                        rst_n,

	input  wire                        ev_valid_i,
	output logic                       ev_ready_o,
	input  wire tcp_ctrl_pkg::ctrl_ev_t ev_i,
	input  wire [15:0]                 peer_port_i,

	input  wire tcp_ctrl_pkg::buf_idx_t buf_sel_idx_i,
	input  wire [`TCP_BUF_NUM-1:0][15:0] buf_len_i,
	output logic                       buf_take_o,
	output logic                       send_ok_o,

	output logic                       cmd_valid_o,
	input  wire                        cmd_ready_i,
	output tcp_ctrl_pkg::tx_cmd_t      cmd_o
);

	import tcp_ctrl_pkg::*;

	localparam int CNT_W = $clog2(`TCP_MAX_INFLIGHT) + 1;

	seq_t        snd_seq_q;
	seq_t        rcv_ack_q;
	seq_t        rcv_next_q;
	seq_t        win_q;
	logic [CNT_W-1:0] pkt_cnt_q;

	logic        cmd_valid_q;
	tx_cmd_t     cmd_q;
	tx_cmd_t     cmd_d;

	logic        ev_fire;
	logic        makes_cmd;
	logic        est_seg;
	logic        in_order;
	seq_t        seg_end;
	logic [15:0] data_len;

	// Accept while the command register is free or draining
	assign ev_ready_o = ~cmd_valid_q | cmd_ready_i;
	assign ev_fire    = ev_valid_i & ev_ready_o;

	assign makes_cmd = ev_i.kind inside {EV_SYNACK, EV_RSTACK, EV_ACK, EV_FINACK, EV_DATA};
	assign est_seg   = ev_i.kind inside {EV_NONE, EV_ACK, EV_FIN_SEEN};
	assign seg_end   = ev_i.seg.seq + 32'(ev_i.seg.len);
	assign in_order  = (ev_i.seg.seq == rcv_next_q);
	assign data_len  = buf_len_i[buf_sel_idx_i];

	assign buf_take_o = ev_fire & (ev_i.kind == EV_DATA);
	assign send_ok_o  = (win_q >= 32'(`TCP_MIN_WINDOW)) &&
		(pkt_cnt_q < CNT_W'(`TCP_MAX_INFLIGHT));

	// --------------------
	// Command forming
	// --------------------
	always_comb
	begin
		cmd_d.dst_port = peer_port_i;
		cmd_d.flags    = '0;
		cmd_d.seq      = snd_seq_q;
		cmd_d.ack      = rcv_ack_q;
		cmd_d.len      = 16'd0;
		cmd_d.buf_idx  = '0;
		case (ev_i.kind)
			EV_SYNACK:
			begin
				cmd_d.dst_port = ev_i.seg.src_port;
				cmd_d.flags    = tcp_flags_t'(6'h12);
				cmd_d.seq      = `TCP_ISS;
				cmd_d.ack      = ev_i.seg.seq + 32'd1;
			end
			EV_RSTACK:
			begin
				// Reply goes to whoever sent the stray ACK
				cmd_d.dst_port = ev_i.seg.src_port;
				cmd_d.flags    = tcp_flags_t'(6'h14);
				cmd_d.seq      = ev_i.seg.ack;
				cmd_d.ack      = ev_i.seg.seq;
			end
			EV_ACK:
			begin
				cmd_d.flags = tcp_flags_t'(6'h10);
				if (in_order)
					cmd_d.ack = seg_end;
			end
			EV_FINACK:
				cmd_d.flags = tcp_flags_t'(6'h11);
			EV_DATA:
			begin
				cmd_d.flags   = tcp_flags_t'(6'h18);
				cmd_d.len     = data_len;
				cmd_d.buf_idx = buf_sel_idx_i;
			end
			default:
				cmd_d.flags = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cmd_valid_q <= 1'b0;
		else if (ev_fire && makes_cmd)
			cmd_valid_q <= 1'b1;
		else if (cmd_ready_i)
			cmd_valid_q <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (ev_fire && makes_cmd)
			cmd_q <= cmd_d;
	end

	// --------------------
	// Connection registers
	// --------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			snd_seq_q  <= '0;
			rcv_ack_q  <= '0;
			rcv_next_q <= '0;
			win_q      <= '0;
			pkt_cnt_q  <= '0;
		end
		else if (ev_fire)
		begin
			if (ev_i.kind == EV_OPEN)
			begin
				snd_seq_q  <= `TCP_ISS + 32'd1;
				rcv_next_q <= seg_end;
				win_q      <= {16'd0, ev_i.seg.window};
			end
			else if (ev_i.kind == EV_DATA)
				snd_seq_q <= snd_seq_q + 32'(data_len);

			if ((ev_i.kind == EV_ACK) && in_order)
			begin
				rcv_ack_q  <= seg_end;
				rcv_next_q <= seg_end;
			end
			else if (ev_i.kind == EV_FIN_SEEN)
				rcv_ack_q <= ev_i.seg.seq + 32'd1;

			// Usable window relative to what is already sent, wraps mod 2^32
			if (est_seg)
				win_q <= ev_i.seg.ack + 32'(ev_i.seg.window) - snd_seq_q;

			if ((est_seg || (ev_i.kind == EV_OPEN)) && ev_i.seg.flags.ack)
				pkt_cnt_q <= '0;
			else if (ev_i.kind == EV_DATA)
				pkt_cnt_q <= pkt_cnt_q + 1'b1;
		end
	end

	assign cmd_valid_o = cmd_valid_q;
	assign cmd_o       = cmd_q;

endmodule

`default_nettype wire

// File: src/tcp_buf_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_buf_arbiter #(
	parameter int N_BUF = 8
) (
	input  wire                     clk,
	input  wire                     rst_n,

	input  wire [N_BUF-1:0]         buf_ready_i,
	input  wire                     take_i,
	output logic                    sel_valid_o,
	output logic [$clog2(N_BUF)-1:0] sel_idx_o
);

	localparam int IW = $clog2(N_BUF);

	logic [N_BUF-1:0] taken_q;
	logic [N_BUF-1:0] eligible;
	logic [IW-1:0]    last_q;
	logic             sel_valid_q;
	logic [IW-1:0]    sel_idx_q;
	logic             nxt_found;
	logic [IW-1:0]    nxt_idx;

	// A taken buffer stays out until its owner drops ready
	assign eligible = buf_ready_i & ~taken_q;

	// Search starts one past the last grant
	always_comb
	begin
		int cand;
		nxt_found = 1'b0;
		nxt_idx   = '0;
		for (int k = 1; k <= N_BUF; k++)
		begin
			cand = (int'(last_q) + k) % N_BUF;
			if (!nxt_found && eligible[cand])
			begin
				nxt_found = 1'b1;
				nxt_idx   = IW'(cand);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			taken_q     <= '0;
			last_q      <= IW'(N_BUF - 1);
			sel_valid_q <= 1'b0;
			sel_idx_q   <= '0;
		end
		else
		begin
			taken_q <= taken_q & buf_ready_i;
			if (take_i)
			begin
				taken_q[sel_idx_q] <= 1'b1;
				last_q             <= sel_idx_q;
				sel_valid_q        <= 1'b0;
			end
			else
			begin
				sel_valid_q <= nxt_found;
				sel_idx_q   <= nxt_idx;
			end
		end
	end

	// Hide a grant whose buffer went away since it was registered
	assign sel_valid_o = sel_valid_q & eligible[sel_idx_q];
	assign sel_idx_o   = sel_idx_q;

endmodule

`default_nettype wire

// File: src/tcp_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_ctrl_consts.svh"

module tcp_ctrl_top (
	input  wire                         clk,
	input  wire                         rst_n,

	input  wire                         rx_valid_i,
	output logic                        rx_ready_o,
	input  wire tcp_ctrl_pkg::rx_seg_t  rx_seg_i,

	output logic                        tx_valid_o,
	input  wire                         tx_ready_i,
	output tcp_ctrl_pkg::tx_cmd_t       tx_cmd_o,

	input  wire [`TCP_BUF_NUM-1:0]      buf_ready_i,
	input  wire [`TCP_BUF_NUM-1:0][15:0] buf_len_i,

	output logic                        state_listen_o,
	output logic                        state_estab_o
);

	import tcp_ctrl_pkg::*;

	logic        seg_valid;
	logic        seg_ready;
	rx_seg_t     seg;
	logic        ev_valid;
	logic        ev_ready;
	ctrl_ev_t    ev;
	logic [15:0] peer_port;
	logic        send_ok;
	logic        buf_sel_valid;
	buf_idx_t    buf_sel_idx;
	logic        buf_take;
	logic        cmd_valid;
	logic        cmd_ready;
	tx_cmd_t     cmd;

	// --------------------
	// Receive side
	// --------------------
	seg_slice #(.payload_t(rx_seg_t)) i_rx_slice (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid_i  (rx_valid_i),
		.in_ready_o  (rx_ready_o),
		.in_data_i   (rx_seg_i),
		.out_valid_o (seg_valid),
		.out_ready_i (seg_ready),
		.out_data_o  (seg)
	);

	tcp_conn_fsm i_conn_fsm (
		.clk             (clk),
		.rst_n           (rst_n),
		.seg_valid_i     (seg_valid),
		.seg_ready_o     (seg_ready),
		.seg_i           (seg),
		.ev_valid_o      (ev_valid),
		.ev_ready_i      (ev_ready),
		.ev_o            (ev),
		.peer_port_o     (peer_port),
		.send_ok_i       (send_ok),
		.buf_sel_valid_i (buf_sel_valid),
		.state_listen_o  (state_listen_o),
		.state_estab_o   (state_estab_o)
	);

	tcp_seg_builder i_seg_builder (
		.clk           (clk),
		.rst_n         (rst_n),
		.ev_valid_i    (ev_valid),
		.ev_ready_o    (ev_ready),
		.ev_i          (ev),
		.peer_port_i   (peer_port),
		.buf_sel_idx_i (buf_sel_idx),
		.buf_len_i     (buf_len_i),
		.buf_take_o    (buf_take),
		.send_ok_o     (send_ok),
		.cmd_valid_o   (cmd_valid),
		.cmd_ready_i   (cmd_ready),
		.cmd_o         (cmd)
	);

	tcp_buf_arbiter #(.N_BUF(`TCP_BUF_NUM)) i_buf_arbiter (
		.clk         (clk),
		.rst_n       (rst_n),
		.buf_ready_i (buf_ready_i),
		.take_i      (buf_take),
		.sel_valid_o (buf_sel_valid),
		.sel_idx_o   (buf_sel_idx)
	);

	// --------------------
	// Transmit side
	// --------------------
	seg_slice #(.payload_t(tx_cmd_t)) i_tx_slice (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid_i  (cmd_valid),
		.in_ready_o  (cmd_ready),
		.in_data_i   (cmd),
		.out_valid_o (tx_valid_o),
		.out_ready_i (tx_ready_i),
		.out_data_o  (tx_cmd_o)
	);

endmodule

`default_nettype wire

// File: tb/tcp_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_ctrl_consts.svh"

module tcp_ctrl_tb;

	import tcp_ctrl_pkg::*;

	localparam int NB         = `TCP_BUF_NUM;
	localparam int MAX_CYCLES = 20000;

	logic                clk;
	logic                rst_n;
	logic                rx_valid_i;
	logic                rx_ready_o;
	rx_seg_t             rx_seg_i;
	logic                tx_valid_o;
	logic                tx_ready_i = 1'b0;
	tx_cmd_t             tx_cmd_o;
	logic [NB-1:0]       buf_ready_i = '0;
	logic [NB-1:0][15:0] buf_len_i = '0;
	logic                state_listen_o;
	logic                state_estab_o;

	// Reference model of the connection
	seq_t        snd_seq = `TCP_ISS + 32'd1;
	seq_t        rcv_ack;
	seq_t        rcv_next;
	logic [15:0] peer_port;
	tx_cmd_t     exp_q[$];
	bit          exp_live_q[$];
	string       exp_name_q[$];

	// Buffer owner state
	logic [NB-1:0] full = '0;
	int            hold [NB] = '{default: 0};
	bit            bufs_on;
	bit            stall_on;
	bit            win_closed;
	int            data_cnt = 0;
	int            cycles = 0;

	tcp_ctrl_top i_tcp_ctrl_top (
		.clk            (clk),
		.rst_n          (rst_n),
		.rx_valid_i     (rx_valid_i),
		.rx_ready_o     (rx_ready_o),
		.rx_seg_i       (rx_seg_i),
		.tx_valid_o     (tx_valid_o),
		.tx_ready_i     (tx_ready_i),
		.tx_cmd_o       (tx_cmd_o),
		.buf_ready_i    (buf_ready_i),
		.buf_len_i      (buf_len_i),
		.state_listen_o (state_listen_o),
		.state_estab_o  (state_estab_o)
	);

	always #20 clk = ~clk;

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act)
		begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic fail_run(input string why);
		$display("ERROR %s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	function automatic rx_seg_t make_seg(input logic [5:0] flags, input seq_t seq,
		input seq_t ack, input logic [15:0] len, input logic [15:0] window);
		rx_seg_t s;
		s.src_port = peer_port;
		s.dst_port = `TCP_LOCAL_PORT;
		s.flags    = tcp_flags_t'(flags);
		s.seq      = seq;
		s.ack      = ack;
		s.len      = len;
		s.window   = window;
		return s;
	endfunction

	// Live entries take their seq from the running send sequence at output time
	task automatic expect_cmd(input string name, input logic [15:0] dst,
		input logic [5:0] flags, input seq_t seq, input seq_t ack, input bit live);
		tx_cmd_t c;
		c          = '0;
		c.dst_port = dst;
		c.flags    = tcp_flags_t'(flags);
		c.seq      = seq;
		c.ack      = ack;
		exp_q.push_back(c);
		exp_live_q.push_back(live);
		exp_name_q.push_back(name);
	endtask

	task automatic send_seg(input rx_seg_t s);
		logic taken;
		@(negedge clk);
		rx_valid_i = 1'b1;
		rx_seg_i   = s;
		taken      = 1'b0;
		while (!taken)
		begin
			taken = rx_ready_o;
			@(negedge clk);
		end
		rx_valid_i = 1'b0;
	endtask

	// Drain expected replies with the encoder always ready and let the pipe settle
	task automatic wait_idle();
		bit prev;
		@(posedge clk);
		prev     = stall_on;
		stall_on = 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (8) @(posedge clk);
		stall_on = prev;
	endtask

	task automatic check_data(input tx_cmd_t c);
		buf_idx_t k;
		k = c.buf_idx;
		if (!state_estab_o)
			fail_run("data command outside ESTABLISHED");
		if (!full[k])
			fail_run("data command from a buffer that held no data");
		if (win_closed)
			fail_run("data command while the peer window was below the minimum");
		compare("data dst", 64'(peer_port), 64'(c.dst_port));
		compare("data seq", 64'(snd_seq), 64'(c.seq));
		compare("data len", 64'(buf_len_i[k]), 64'(c.len));
		snd_seq = snd_seq + 32'(c.len);
		data_cnt++;
		full[k] = 1'b0;
		hold[k] = $urandom_range(1, 12);
	endtask

	task automatic check_ctrl(input tx_cmd_t c);
		tx_cmd_t want;
		string   name;
		if (exp_q.size() == 0)
			fail_run("control command that no segment called for");
		want = exp_q.pop_front();
		name = exp_name_q.pop_front();
		if (exp_live_q.pop_front())
			want.seq = snd_seq;
		compare({name, " dst"}, 64'(want.dst_port), 64'(c.dst_port));
		compare({name, " flags"}, 64'(want.flags), 64'(c.flags));
		compare({name, " seq"}, 64'(want.seq), 64'(c.seq));
		compare({name, " ack"}, 64'(want.ack), 64'(c.ack));
		compare({name, " len"}, 64'(16'd0), 64'(c.len));
	endtask

	// --------------------
	// Encoder and buffers
	// --------------------
	always @(negedge clk)
	begin : tx_monitor
		bit go;
		cycles++;
		if (cycles >= MAX_CYCLES)
			fail_run("timeout, the tests did not finish within the cycle limit");
		go = !stall_on || ($urandom_range(0, 9) < 7);
		// Output is stable here and moves at the next rising edge
		if (rst_n && go && tx_valid_o)
		begin
			if (tx_cmd_o.flags == 6'h18)
				check_data(tx_cmd_o);
			else
				check_ctrl(tx_cmd_o);
		end
		for (int k = 0; k < NB; k++)
		begin
			if (!full[k])
			begin
				if (hold[k] > 0)
					hold[k]--;
				else
				begin
					buf_len_i[k] = 16'($urandom_range(1, 1460));
					full[k]      = 1'b1;
				end
			end
		end
		buf_ready_i = full & {NB{bufs_on}};
		tx_ready_i  = go;
	end

	// --------------------
	// Test sequence
	// --------------------
	initial
	begin : run_tests
		seq_t        irs;
		rx_seg_t     s;
		logic [15:0] len;
		int          base;
		int          n;
		int          pick;

		clk        = 1'b0;
		rst_n      = 1'b0;
		rx_valid_i = 1'b0;
		rx_seg_i   = '0;
		// Buffers hold data from the start, so LISTEN and SYN_RCVD see ready data
		bufs_on    = 1'b1;
		stall_on   = 1'b1;
		win_closed = 1'b0;
		rcv_ack    = '0;
		rcv_next   = '0;
		void'($urandom(32'h27d9));
		peer_port = 16'($urandom_range(1024, 65535));

		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		compare("reset tx_valid", 64'd0, 64'(tx_valid_o));
		compare("reset rx_ready", 64'd1, 64'(rx_ready_o));
		compare("reset listen", 64'd1, 64'(state_listen_o));

		// Stray ACK in LISTEN gets a reply with the numbers swapped
		@(posedge clk);
		s          = make_seg(6'h10, $urandom(), $urandom(), 16'd0, 16'd1000);
		s.src_port = 16'($urandom_range(1024, 65535));
		expect_cmd("rstack", s.src_port, 6'h14, s.ack, s.seq, 1'b0);
		send_seg(s);
		wait_idle();
		@(negedge clk);
		compare("listen after stray ack", 64'd1, 64'(state_listen_o));

		// Three-way handshake
		@(posedge clk);
		irs = $urandom();
		expect_cmd("synack", peer_port, 6'h12, `TCP_ISS, irs + 32'd1, 1'b0);
		send_seg(make_seg(6'h02, irs, 32'd0, 16'd0, 16'hffff));
		wait_idle();
		rcv_next = irs + 32'd1;
		send_seg(make_seg(6'h10, rcv_next, `TCP_ISS + 32'd1, 16'd0, 16'hffff));
		wait_idle();
		@(negedge clk);
		compare("estab after handshake", 64'd1, 64'(state_estab_o));

		// Peer data mixed with our data under random stalls
		@(posedge clk);
		for (n = 0; n < 80; n++)
		begin
			@(posedge clk);
			pick = $urandom_range(0, 9);
			len  = 16'($urandom_range(1, 1200));
			if (pick < 5)
			begin
				s        = make_seg(6'h18, rcv_next, snd_seq, len, 16'hffff);
				rcv_next = rcv_next + 32'(len);
				rcv_ack  = rcv_next;
				expect_cmd("in-order ack", peer_port, 6'h10, 32'd0, rcv_ack, 1'b1);
			end
			else if (pick < 8)
			begin
				s = make_seg(6'h18, rcv_next + 32'd5000 + 32'($urandom_range(0, 9999)),
					snd_seq, len, 16'hffff);
				expect_cmd("out-of-order ack", peer_port, 6'h10, 32'd0, rcv_ack, 1'b1);
			end
			else
				s = make_seg(6'h10, rcv_next, snd_seq, 16'd0, 16'hffff);
			send_seg(s);
			repeat ($urandom_range(0, 6)) @(posedge clk);
		end
		@(posedge clk);
		bufs_on = 1'b0;
		wait_idle();
		if (data_cnt == 0)
			fail_run("no data command was sent while established");

		// Burst without peer ACKs stops at the in-flight limit
		send_seg(make_seg(6'h10, rcv_next, snd_seq, 16'd0, 16'hffff));
		wait_idle();
		base    = data_cnt;
		bufs_on = 1'b1;
		while (data_cnt - base < `TCP_MAX_INFLIGHT)
			@(posedge clk);
		repeat (60) @(posedge clk);
		compare("inflight limit", 64'(`TCP_MAX_INFLIGHT), 64'(data_cnt - base));

		// Small window holds data back until the peer opens it
		bufs_on = 1'b0;
		wait_idle();
		win_closed = 1'b1;
		send_seg(make_seg(6'h10, rcv_next, snd_seq, 16'd0, 16'(`TCP_MIN_WINDOW - 5000)));
		wait_idle();
		bufs_on = 1'b1;
		repeat (60) @(posedge clk);
		base       = data_cnt;
		win_closed = 1'b0;
		send_seg(make_seg(6'h10, rcv_next, snd_seq, 16'd0, 16'hffff));
		@(posedge clk);
		while (data_cnt == base)
			@(posedge clk);

		// Passive close
		bufs_on = 1'b0;
		wait_idle();
		rcv_ack = rcv_next + 32'd1;
		expect_cmd("finack", peer_port, 6'h11, 32'd0, rcv_ack, 1'b1);
		send_seg(make_seg(6'h11, rcv_next, snd_seq, 16'd0, 16'hffff));
		wait_idle();
		send_seg(make_seg(6'h10, rcv_next + 32'd1, snd_seq + 32'd1, 16'd0, 16'hffff));
		n = 0;
		while (!state_listen_o && (n < 8))
		begin
			@(negedge clk);
			n++;
		end
		if (!state_listen_o)
			fail_run("state machine did not return to LISTEN after the final ACK");

		@(posedge clk);
		if (exp_q.size() == 0)
		begin
			$display("Regression passed");
			$finish;
		end
		else
		begin
			$display("ERROR %0d expected control commands never appeared", exp_q.size());
			$display("Regression failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+src
src/tcp_ctrl_pkg.sv
src/seg_slice.sv
src/tcp_conn_fsm.sv
src/tcp_seg_builder.sv
src/tcp_buf_arbiter.sv
src/tcp_ctrl_top.sv
tb/tcp_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing -j 0
TOP       ?= tcp_ctrl_tb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
PASS_MSG  := Regression passed

.PHONY: all lint sim clean

all: sim

# Static checks over the whole source set
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run; the exit status follows the pass line in the output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
